/* Bender.yml */
package:
  name: vertex_job_control

sources:
  - wb_pkg.sv
  - graph_pkg.sv
  - vertex_fetch.sv
  - vertex_job_fifo.sv
  - vertex_job_dispatch.sv
  - vertex_job_control.sv
  - target: test
    files:
      - vertex_job_control_sva.sv
      - tb_vertex_job_control.sv

/* graph_pkg.sv */
// graph job types
`default_nettype none

package graph_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	// vertex ids and vertex counts
	localparam int VERTEX_ID_BITS = 16;

	// out-degree and edge index values
	localparam int DEGREE_BITS = 32;

	typedef logic [VERTEX_ID_BITS-1:0] vertex_id_t;
	typedef logic [DEGREE_BITS-1:0]    degree_t;

	////////////////////////////////////////
	// job descriptor and vertex record
	////////////////////////////////////////

	// one job: how many vertices and where their arrays start
	typedef struct packed {
		vertex_id_t       vertex_count;
		wb_pkg::wb_addr_t out_degree_base;
		wb_pkg::wb_addr_t edges_idx_base;
	} job_desc_t;

	// one vertex as seen by the compute side
	typedef struct packed {
		vertex_id_t id;
		degree_t    out_degree;
		degree_t    edges_idx;
	} vertex_job_t;

	////////////////////////////////////////
	// fetch FSM
	////////////////////////////////////////

	typedef enum logic [2:0] {
		FETCH_IDLE        = 3'd0,
		// hold off until the buffer can take one more record
		FETCH_WAIT_SPACE  = 3'd1,
		FETCH_READ_DEGREE = 3'd2,
		FETCH_READ_EDGES  = 3'd3,
		FETCH_PUSH        = 3'd4
	} fetch_state_t;

endpackage

`default_nettype wire

/* tb_vertex_job_control.sv */
// vertex job control testbench
`timescale 1ns/100ps
`default_nettype none

module tb_vertex_job_control;

	import graph_pkg::*;
	import wb_pkg::*;

	localparam int FIFO_DEPTH = 8;
	localparam int MEM_WORDS  = 256;
	localparam int NUM_ROWS   = 4;
	localparam int WAIT_LIMIT = 4000;

	// one start descriptor and its expected filter count
	typedef struct packed {
		job_desc_t  desc;
		logic       stall_ready;
		vertex_id_t exp_filtered;
	} row_t;

	logic        clock;
	logic        rstn;
	logic        start;
	job_desc_t   desc;
	logic        busy;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	vertex_job_t job;
	logic        job_valid;
	logic        job_ready;
	vertex_id_t  filtered_count;

	wb_data_t    mem [MEM_WORDS];
	row_t        rows [NUM_ROWS];
	vertex_job_t exp_q [$];
	job_desc_t   cur_desc;
	logic [31:0] rng_state;
	logic        hold_low;
	logic        active;
	int          wait_cnt;
	int          wb_cycles;

	vertex_job_control #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) vertex_job_control_inst (
		.clock         (clock),
		.rstn          (rstn),
		.start         (start),
		.desc          (desc),
		.busy          (busy),
		.wb_req        (wb_req),
		.wb_rsp        (wb_rsp),
		.job           (job),
		.job_valid     (job_valid),
		.job_ready     (job_ready),
		.filtered_count(filtered_count)
	);

	always #5 clock = ~clock;

	// xorshift32
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic in_array(wb_addr_t adr, wb_addr_t base, vertex_id_t count);
		return adr[1:0] == 2'b00 && adr >= base &&
			adr < base + wb_addr_t'(count) * wb_addr_t'(WORD_BYTES);
	endfunction

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_job(input vertex_job_t got, input vertex_job_t exp);
		if (got !== exp)
			stop_run($sformatf("mismatch at %0t: job got %0d/%h/%h, expected %0d/%h/%h",
				$time, got.id, got.out_degree, got.edges_idx,
				exp.id, exp.out_degree, exp.edges_idx));
	endtask

	task automatic check_count(input vertex_id_t got, input vertex_id_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("mismatch at %0t: %s got %0d, expected %0d",
				$time, what, got, exp));
	endtask

	// expected jobs follow base plus four times the vertex id
	task automatic load_expected(input int r);
		vertex_job_t exp_job;
		int          deg_word;
		int          edge_word;
		rows[r].exp_filtered = '0;
		for (int i = 0; i < int'(rows[r].desc.vertex_count); i++) begin
			deg_word  = int'(rows[r].desc.out_degree_base) / WORD_BYTES + i;
			edge_word = int'(rows[r].desc.edges_idx_base) / WORD_BYTES + i;
			if (mem[deg_word] == '0) begin
				rows[r].exp_filtered = rows[r].exp_filtered + vertex_id_t'(1);
			end else begin
				exp_job = '{vertex_id_t'(i), mem[deg_word], mem[edge_word]};
				exp_q.push_back(exp_job);
			end
		end
	endtask

	task automatic wait_done();
		int t;
		t = 0;
		while ((busy || exp_q.size() != 0) && t < WAIT_LIMIT) begin
			@(negedge clock);
			t = t + 1;
		end
		if (busy || exp_q.size() != 0)
			stop_run("timeout: the job did not finish or some jobs never came out");
	endtask

	////////////////////////////////////////
	// memory slave and consumer
	////////////////////////////////////////
	always @(negedge clock) begin
		job_ready <= hold_low ? 1'b0 : (next_rand() % 3 != 0);
		if (wb_rsp.ack) begin
			wb_rsp.ack <= 1'b0;
			active = 1'b0;
		end else if (wb_req.cyc && wb_req.stb) begin
			if (!active) begin
				active    = 1'b1;
				wait_cnt  = int'(next_rand() % 4);
				wb_cycles = wb_cycles + 1;
				if (!in_array(wb_req.adr, cur_desc.out_degree_base, cur_desc.vertex_count) &&
					!in_array(wb_req.adr, cur_desc.edges_idx_base, cur_desc.vertex_count))
					stop_run($sformatf("read address %h lies outside both arrays", wb_req.adr));
			end
			if (wait_cnt == 0) begin
				wb_rsp.ack <= 1'b1;
				wb_rsp.dat <= mem[wb_req.adr[9:2]];
			end else begin
				wait_cnt = wait_cnt - 1;
			end
		end
	end

	always @(posedge clock) begin : take_job
		vertex_job_t exp_job;
		if (rstn && job_valid && job_ready) begin
			if (exp_q.size() == 0) begin
				stop_run("a job came out although none was expected");
			end else begin
				exp_job = exp_q.pop_front();
				check_job(job, exp_job);
			end
		end
	end

	// bound assertion failures end the run at once
	always @(negedge clock) begin
		if (vertex_job_control_inst.vertex_job_control_sva_inst.fail_count != 0)
			stop_run("an assertion on the bus or job handshake failed");
	end

	////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////
	initial begin
		vertex_id_t filtered_total;
		int         cycles_before;
		clock     = 1'b0;
		rstn      = 1'b0;
		start     = 1'b0;
		desc      = '0;
		job_ready = 1'b0;
		wb_rsp    = '0;
		hold_low  = 1'b0;
		active    = 1'b0;
		wait_cnt  = 0;
		wb_cycles = 0;
		cur_desc  = '0;
		filtered_total = '0;
		rng_state = 32'd7;
		// about one word in four becomes zero
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = next_rand();
			if (mem[i][1:0] == 2'b00)
				mem[i] = '0;
		end
		rows[0] = '{'{16'd5, 32'h000, 32'h100}, 1'b0, '0};
		rows[1] = '{'{16'd0, 32'h200, 32'h300}, 1'b0, '0};
		rows[2] = '{'{16'(FIFO_DEPTH * 3), 32'h040, 32'h140}, 1'b1, '0};
		rows[3] = '{'{16'd12, 32'h200, 32'h280}, 1'b0, '0};

		repeat (10) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		check_count(filtered_count, '0, "filtered count after reset");

		for (int r = 0; r < NUM_ROWS; r++) begin
			load_expected(r);
			cycles_before = wb_cycles;
			cur_desc      = rows[r].desc;
			hold_low      = rows[r].stall_ready;
			start = 1'b1;
			desc  = rows[r].desc;
			@(negedge clock);
			// a second start while busy must be ignored
			start = (rows[r].desc.vertex_count != '0);
			desc  = '{16'd3, 32'h3f0, 32'h3e0};
			if (busy !== (rows[r].desc.vertex_count != '0))
				stop_run("busy did not follow the start pulse as expected");
			@(negedge clock);
			start = 1'b0;
			desc  = '0;
			if (rows[r].stall_ready) begin
				// long enough to fetch the whole row if nothing held the fetch back
				repeat (FIFO_DEPTH * 48) @(negedge clock);
				// buffer and output register hold at most FIFO_DEPTH kept records
				if (exp_q.size() > FIFO_DEPTH && !busy)
					stop_run("the fetch unit ran on although the job buffer was full");
				hold_low = 1'b0;
			end
			wait_done();
			// dispatcher drains the buffer at one record per cycle
			repeat (FIFO_DEPTH + 4) @(negedge clock);
			filtered_total = filtered_total + rows[r].exp_filtered;
			check_count(filtered_count, filtered_total, "filtered count");
			if (wb_cycles - cycles_before != 2 * int'(rows[r].desc.vertex_count))
				stop_run("the number of Wishbone reads does not match the vertex count");
		end

		if (vertex_job_control_inst.vertex_job_control_sva_inst.fail_count != 0) begin
			stop_run("an assertion on the bus or job handshake failed");
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verilog.f */
wb_pkg.sv
graph_pkg.sv
vertex_fetch.sv
vertex_job_fifo.sv
vertex_job_dispatch.sv
vertex_job_control.sv
vertex_job_control_sva.sv
tb_vertex_job_control.sv

/* vertex_fetch.sv */
// vertex record fetch unit
`timescale 1ns/100ps
`default_nettype none

module vertex_fetch (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   start,
	input  graph_pkg::job_desc_t   desc,
	output logic                   busy,
	output wb_pkg::wb_req_t        wb_req,
	input  wb_pkg::wb_rsp_t        wb_rsp,
	input  logic                   almost_full,
	output logic                   push,
	output graph_pkg::vertex_job_t record
);

	import graph_pkg::*;
	import wb_pkg::*;

	fetch_state_t state;
	fetch_state_t next_state;

	// latched array bases of the running job
	wb_addr_t out_degree_base_q;
	wb_addr_t edges_idx_base_q;

	vertex_id_t remaining;
	vertex_id_t vertex_id;
	wb_addr_t   offset;

	logic     req_cyc;
	wb_addr_t req_adr;
	logic     ack_seen;
	logic     issue;

	assign ack_seen = req_cyc && wb_rsp.ack;

	// a read starts one cycle after entering a read state, which leaves
	// cyc low for at least one cycle between two reads
	assign issue = !req_cyc &&
		(state == FETCH_READ_DEGREE || state == FETCH_READ_EDGES);

	assign wb_req = '{cyc: req_cyc, stb: req_cyc, adr: req_adr};
	assign busy   = (state != FETCH_IDLE);
	assign push   = (state == FETCH_PUSH);

	////////////////////////////////////////
	// next state
	////////////////////////////////////////
	always_comb begin
		next_state = state;
		case (state)
			FETCH_IDLE: begin
				// empty jobs never leave idle
				if (start && desc.vertex_count != '0)
					next_state = FETCH_WAIT_SPACE;
			end
			FETCH_WAIT_SPACE: begin
				if (!almost_full)
					next_state = FETCH_READ_DEGREE;
			end
			FETCH_READ_DEGREE: begin
				if (ack_seen)
					next_state = FETCH_READ_EDGES;
			end
			FETCH_READ_EDGES: begin
				if (ack_seen)
					next_state = FETCH_PUSH;
			end
			FETCH_PUSH: begin
				if (remaining == vertex_id_t'(1))
					next_state = FETCH_IDLE;
				else
					next_state = FETCH_WAIT_SPACE;
			end
			default: next_state = FETCH_IDLE;
		endcase
	end

	////////////////////////////////////////
	// control state
	////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= FETCH_IDLE;
			req_cyc   <= 1'b0;
			remaining <= '0;
			vertex_id <= '0;
			offset    <= '0;
		end else begin
			state <= next_state;

			if (ack_seen)
				req_cyc <= 1'b0;
			else if (issue)
				req_cyc <= 1'b1;

			if (state == FETCH_IDLE && start) begin
				// ids and offsets restart for every job
				remaining <= desc.vertex_count;
				vertex_id <= '0;
				offset    <= '0;
			end else if (push) begin
				remaining <= remaining - vertex_id_t'(1);
				vertex_id <= vertex_id + vertex_id_t'(1);
				offset    <= offset + wb_addr_t'(WORD_BYTES);
			end
		end
	end

	////////////////////////////////////////
	// descriptor, address and record data
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (state == FETCH_IDLE && start) begin
			out_degree_base_q <= desc.out_degree_base;
			edges_idx_base_q  <= desc.edges_idx_base;
		end

		// address stays put until the ack
		if (issue) begin
			if (state == FETCH_READ_DEGREE)
				req_adr <= out_degree_base_q + offset;
			else
				req_adr <= edges_idx_base_q + offset;
		end

		if (ack_seen && state == FETCH_READ_DEGREE) begin
			record.id         <= vertex_id;
			record.out_degree <= wb_rsp.dat;
		end
		if (ack_seen && state == FETCH_READ_EDGES)
			record.edges_idx <= wb_rsp.dat;
	end

endmodule

`default_nettype wire

/* vertex_job_control.sv */
// vertex job control top level
`timescale 1ns/100ps
`default_nettype none

module vertex_job_control #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   start,
	input  graph_pkg::job_desc_t   desc,
	output logic                   busy,
	output wb_pkg::wb_req_t        wb_req,
	input  wb_pkg::wb_rsp_t        wb_rsp,
	output graph_pkg::vertex_job_t job,
	output logic                   job_valid,
	input  logic                   job_ready,
	output graph_pkg::vertex_id_t  filtered_count
);

	import graph_pkg::*;

	// fetch to buffer
	logic        fetch_push;
	vertex_job_t fetch_record;
	logic        fifo_almost_full;

	// buffer to dispatcher
	vertex_job_t fifo_head;
	logic        fifo_empty;
	logic        dispatch_pop;

	////////////////////////////////////////
	// producer
	////////////////////////////////////////
	vertex_fetch vertex_fetch_inst (
		.clock      (clock),
		.rstn       (rstn),
		.start      (start),
		.desc       (desc),
		.busy       (busy),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.almost_full(fifo_almost_full),
		.push       (fetch_push),
		.record     (fetch_record)
	);

	////////////////////////////////////////
	// record buffer
	////////////////////////////////////////
	vertex_job_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) vertex_job_fifo_inst (
		.clock      (clock),
		.rstn       (rstn),
		.push       (fetch_push),
		.push_record(fetch_record),
		.almost_full(fifo_almost_full),
		.pop        (dispatch_pop),
		.head       (fifo_head),
		.empty      (fifo_empty)
	);

	////////////////////////////////////////
	// consumer
	////////////////////////////////////////
	vertex_job_dispatch vertex_job_dispatch_inst (
		.clock         (clock),
		.rstn          (rstn),
		.empty         (fifo_empty),
		.head          (fifo_head),
		.pop           (dispatch_pop),
		.job           (job),
		.job_valid     (job_valid),
		.job_ready     (job_ready),
		.filtered_count(filtered_count)
	);

endmodule

`default_nettype wire

/* vertex_job_control_sva.sv */
// vertex job control assertions
`timescale 1ns/100ps
`default_nettype none

module vertex_job_control_sva (
	input logic                   clock,
	input logic                   rstn,
	input wb_pkg::wb_req_t        wb_req,
	input wb_pkg::wb_rsp_t        wb_rsp,
	input graph_pkg::vertex_job_t job,
	input logic                   job_valid,
	input logic                   job_ready
);

	import graph_pkg::*;
	import wb_pkg::*;

	// failed checks so far
	int fail_count = 0;

	////////////////////////////////////////
	// wishbone classic
	////////////////////////////////////////
	stb_needs_cyc: assert property (@(posedge clock) disable iff (!rstn)
		wb_req.stb |-> wb_req.cyc)
		else begin
			fail_count = fail_count + 1;
			$error("stb high without cyc");
		end

	// address held until the slave answers
	adr_stable: assert property (@(posedge clock) disable iff (!rstn)
		wb_req.stb && !wb_rsp.ack |=> $stable(wb_req.adr))
		else begin
			fail_count = fail_count + 1;
			$error("address changed before ack");
		end

	////////////////////////////////////////
	// job handshake
	////////////////////////////////////////
	job_held: assert property (@(posedge clock) disable iff (!rstn)
		job_valid && !job_ready |=> job_valid && $stable(job))
		else begin
			fail_count = fail_count + 1;
			$error("job changed while stalled");
		end

	valid_low_in_reset: assert property (@(posedge clock)
		!rstn |-> !job_valid)
		else begin
			fail_count = fail_count + 1;
			$error("job_valid high during reset");
		end

endmodule

bind vertex_job_control vertex_job_control_sva vertex_job_control_sva_inst (
	.clock    (clock),
	.rstn     (rstn),
	.wb_req   (wb_req),
	.wb_rsp   (wb_rsp),
	.job      (job),
	.job_valid(job_valid),
	.job_ready(job_ready)
);

`default_nettype wire

/* vertex_job_dispatch.sv */
// vertex job dispatcher
`timescale 1ns/100ps
`default_nettype none

module vertex_job_dispatch (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   empty,
	input  graph_pkg::vertex_job_t head,
	output logic                   pop,
	output graph_pkg::vertex_job_t job,
	output logic                   job_valid,
	input  logic                   job_ready,
	output graph_pkg::vertex_id_t  filtered_count
);

	import graph_pkg::*;

	vertex_job_t job_q;
	logic        taken;
	logic        keep;

	assign taken = job_valid && job_ready;

	// pop when the output slot is free now or frees this cycle
	assign pop  = !empty && (!job_valid || taken);

	// vertices without outgoing edges carry no work
	assign keep = (head.out_degree != '0);

	assign job = job_q;

	////////////////////////////////////////
	// handshake and filter counter
	////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_valid      <= 1'b0;
			filtered_count <= '0;
		end else begin
			if (pop && keep)
				job_valid <= 1'b1;
			else if (taken)
				job_valid <= 1'b0;

			if (pop && !keep)
				filtered_count <= filtered_count + vertex_id_t'(1);
		end
	end

	// output register, held while the consumer stalls
	always_ff @(posedge clock) begin
		if (pop && keep)
			job_q <= head;
	end

endmodule

`default_nettype wire

/* vertex_job_fifo.sv */
// vertex record buffer
`timescale 1ns/100ps
`default_nettype none

module vertex_job_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   push,
	input  graph_pkg::vertex_job_t push_record,
	output logic                   almost_full,
	input  logic                   pop,
	output graph_pkg::vertex_job_t head,
	output logic                   empty
);

	import graph_pkg::*;

	localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

	vertex_job_t mem [FIFO_DEPTH];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;

	logic full;
	logic wr_en;
	logic rd_en;

	// wrap at the depth, which need not be a power of two
	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(FIFO_DEPTH - 1))
			return '0;
		else
			return ptr + PTR_BITS'(1);
	endfunction

	assign full        = (count == CNT_BITS'(FIFO_DEPTH));
	assign empty       = (count == '0);
	// one slot kept back for the record the fetch unit has in flight
	assign almost_full = (count >= CNT_BITS'(FIFO_DEPTH - 1));

	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	assign head = mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= next_ptr(wr_ptr);
			if (rd_en)
				rd_ptr <= next_ptr(rd_ptr);

			// simultaneous push and pop leave the count alone
			if (wr_en && !rd_en)
				count <= count + CNT_BITS'(1);
			else if (rd_en && !wr_en)
				count <= count - CNT_BITS'(1);
		end
	end

	// storage
	always_ff @(posedge clock) begin
		if (wr_en)
			mem[wr_ptr] <= push_record;
	end

endmodule

`default_nettype wire

/* wb_pkg.sv */
// wishbone bus types
`default_nettype none

package wb_pkg;

	// byte address and data word widths
	localparam int WB_ADDR_BITS = 32;
	localparam int WB_DATA_BITS = 32;

	// one array element is one bus word
	localparam int WORD_BYTES = 4;

	typedef logic [WB_ADDR_BITS-1:0] wb_addr_t;
	typedef logic [WB_DATA_BITS-1:0] wb_data_t;

	// master side of a read-only classic cycle
	typedef struct packed {
		logic     cyc;
		logic     stb;
		wb_addr_t adr;
	} wb_req_t;

	// slave side, one ack cycle per read
	typedef struct packed {
		logic     ack;
		wb_data_t dat;
	} wb_rsp_t;

endpackage

`default_nettype wire
